/* logic/decode.sv */
`timescale 1ns/1ps
// ******************************
// Decode stage: register reads, immediates, branch and
// jump resolution, link and LBI data, wrong-path squash
// ******************************
module decode import wiscIsaPkg::*, wiscPipePkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  fetchOut_t  fetched,
   input  wbReq_t     write,
   output logic       redirect,
   output word_t      redirectPc,
   output logic       haltSeen,
   output decodeOut_t decoded
);

   instr_u   ins;
   opcode_t  opcode;
   word_t    rsData, rtData;
   word_t    pcPlus2, immI, immB, dispJ;
   logic     inValid, squashQ, haltQ;
   logic     rsZero, rsNeg;
   logic     takeBr, isHalt, writes;
   aluOp_t   aluOp;
   regAddr_t dest;
   word_t    opA, opB, imm;

   assign ins    = fetched.instr;
   assign opcode = ins.r.opcode;    // Opcode sits in the same bits in every format

   // The slot right after a redirect is dropped here as well as in fetch
   assign inValid = fetched.valid & ~squashQ;

   regFile regs (
      .clk       (clk),
      .rst       (rst),
      .readAddr1 (ins.r.rs),
      .readAddr2 (ins.r.rt),
      .readData1 (rsData),
      .readData2 (rtData),
      .write     (write)
   );

   assign pcPlus2 = fetched.pc + 16'd2;
   assign immI    = {{11{ins.i.imm[4]}}, ins.i.imm};
   assign immB    = {{8{ins.b.imm[7]}}, ins.b.imm};
   assign dispJ   = {{5{ins.j.disp[10]}}, ins.j.disp};

   assign rsZero = (rsData == '0);
   assign rsNeg  = rsData[15];      // Sign bit decides BLTZ and BGEZ

   always_comb begin
      aluOp      = aluPass;
      dest       = ins.i.rd;
      writes     = 1'b0;
      opA        = rsData;
      opB        = rtData;
      imm        = immI;
      isHalt     = 1'b0;
      takeBr     = 1'b0;
      redirectPc = pcPlus2 + immB;   // Branch target unless a jump overrides it
      case (opcode)
         opHalt: begin
            isHalt = 1'b1;
            opA    = fetched.pc;      // Carried down so the top can report it
         end
         opAddi, opSubi: begin
            aluOp  = (opcode == opSubi) ? aluSubI : aluAddI;
            writes = 1'b1;
         end
         opLbi: begin
            dest   = ins.b.rs;        // LBI writes the register named in Rs
            writes = 1'b1;
            opB    = immB;
            imm    = immB;
         end
         opAluR: begin
            dest   = ins.r.rd;
            writes = (ins.r.func == funcAdd) || (ins.r.func == funcSub);
            aluOp  = (ins.r.func == funcSub) ? aluSub : aluAdd;
         end
         opBeqz: takeBr = rsZero;
         opBnez: takeBr = ~rsZero;
         opBltz: takeBr = rsNeg;
         opBgez: takeBr = ~rsNeg;
         opJ, opJal: begin
            takeBr     = 1'b1;
            redirectPc = pcPlus2 + dispJ;
            imm        = dispJ;
         end
         opJr, opJalr: begin
            takeBr     = 1'b1;
            redirectPc = rsData + immB;
            imm        = immB;
         end
         default: ;                   // NOP and unused opcodes do nothing
      endcase
      if ((opcode == opJal) || (opcode == opJalr)) begin
         dest   = linkReg;
         writes = 1'b1;
         opB    = pcPlus2;            // Return address goes through the ALU unchanged
      end
   end

   // HALT never steers fetch, whatever shares its slot
   assign redirect = inValid & takeBr & ~isHalt;
   assign haltSeen = haltQ | (inValid & isHalt);

   always_ff @(posedge clk) begin
      if (rst) begin
         squashQ       <= 1'b0;
         haltQ         <= 1'b0;
         decoded.valid <= 1'b0;
      end else begin
         squashQ       <= redirect;
         haltQ         <= haltSeen;   // Sticky until the next reset
         decoded.valid <= inValid;
      end

      // Payload holds through empty slots, so opA still has the HALT's PC
      if (inValid) begin
         decoded.halt   <= isHalt;
         decoded.op     <= aluOp;
         decoded.dest   <= dest;
         decoded.writes <= writes;
         decoded.opA    <= opA;
         decoded.opB    <= opB;
         decoded.imm    <= imm;
      end
   end

endmodule

/* logic/execute.sv */
`timescale 1ns/1ps
// ******************************
// Execute stage: ALU, writeback request to the register
// file, registered retire record and halt flag
// ******************************
module execute import wiscIsaPkg::*, wiscPipePkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  decodeOut_t decoded,
   output wbReq_t     write,
   output wbReq_t     retire,
   output logic       halted
);

   word_t srcB;
   word_t result;
   logic  useImm;

   // Immediate forms take their second operand from the immediate field
   assign useImm = (decoded.op == aluAddI) || (decoded.op == aluSubI);
   assign srcB   = useImm ? decoded.imm : decoded.opB;

   always_comb begin
      case (decoded.op)
         aluAdd, aluAddI: result = decoded.opA + srcB;
         aluSub, aluSubI: result = srcB - decoded.opA;   // WISC subtracts Rs from the other side
         default:         result = decoded.opB;          // LBI value or link address
      endcase
   end

   // Goes straight to the register file, written at the end of this cycle
   always_comb begin
      write.valid = decoded.valid & decoded.writes;
      write.addr  = decoded.dest;
      write.data  = result;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         retire.valid <= 1'b0;
         halted       <= 1'b0;
      end else begin
         retire.valid <= write.valid;    // One cycle behind the register write
         if (decoded.valid && decoded.halt) begin
            halted <= 1'b1;             // Stays set until reset
         end
      end

      retire.addr <= write.addr;
      retire.data <= write.data;
   end

endmodule

/* logic/fetch.sv */
`timescale 1ns/1ps
// ******************************
// Fetch stage: PC register, instruction memory with a
// load port, redirect from decode and halt freeze
// ******************************
module fetch import wiscIsaPkg::*, wiscPipePkg::*; #(
   parameter int imemDepth = 64
) (
   input  logic      clk,
   input  logic      rst,
   input  logic      progWe,
   input  word_t     progAddr,    // Byte address, same as the PC
   input  instr_u    progInstr,
   input  logic      redirect,
   input  word_t     redirectPc,
   input  logic      haltSeen,
   output fetchOut_t fetched
);

   localparam int idxW = $clog2(imemDepth);

   instr_u          imem [imemDepth];
   word_t           pc;
   logic [idxW-1:0] fetchIdx;
   logic [idxW-1:0] progIdx;

   // Words are two bytes so bit 0 of an address never selects anything
   assign fetchIdx = pc[idxW:1];
   assign progIdx  = progAddr[idxW:1];

   // Program load port, driven while the core is held in reset
   always_ff @(posedge clk) begin
      if (progWe) begin
         imem[progIdx] <= progInstr;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc            <= '0;     // First fetch comes from address 0
         fetched.valid <= 1'b0;
      end else if (haltSeen) begin
         // HALT sits in decode or beyond, nothing more is issued
         fetched.valid <= 1'b0;
      end else begin
         // A taken transfer in decode means the word read this cycle
         // is on the wrong path
         fetched.valid <= ~redirect;
         if (redirect) begin
            pc <= redirectPc;
         end else begin
            pc <= pc + 16'd2;
         end
      end

      // Payload follows the PC and needs no clearing
      fetched.pc    <= pc;
      fetched.instr <= imem[fetchIdx];
   end

endmodule

/* logic/regFile.sv */
`timescale 1ns/1ps
// ******************************
// Register file: eight 16-bit registers, two
// asynchronous read ports, one write port with
// write-through to the readers
// ******************************
module regFile import wiscIsaPkg::*, wiscPipePkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  regAddr_t readAddr1,
   input  regAddr_t readAddr2,
   output word_t    readData1,
   output word_t    readData2,
   input  wbReq_t   write
);

   word_t regs [8];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;     // Every program starts from zeroed registers
         end
      end else if (write.valid) begin
         regs[write.addr] <= write.data;
      end
   end

   // Execute writes at the end of its cycle while decode already reads the
   // next instruction, so a matching address takes the data in flight
   always_comb begin
      if (write.valid && (write.addr == readAddr1)) begin
         readData1 = write.data;
      end else begin
         readData1 = regs[readAddr1];
      end
   end

   always_comb begin
      if (write.valid && (write.addr == readAddr2)) begin
         readData2 = write.data;
      end else begin
         readData2 = regs[readAddr2];
      end
   end

endmodule

/* logic/wiscCore.sv */
`timescale 1ns/1ps
// ******************************
// Core top level: fetch, decode and execute wired into
// a three stage pipeline
// ******************************
module wiscCore import wiscIsaPkg::*, wiscPipePkg::*; #(
   parameter int imemDepth = 64
) (
   input  logic   clk,
   input  logic   rst,
   input  logic   progWe,
   input  word_t  progAddr,
   input  instr_u progInstr,
   output wbReq_t retire,
   output logic   halted,
   output word_t  haltPc
);

   fetchOut_t  fetchedBus;
   decodeOut_t decodedBus;
   wbReq_t     writeBus;
   logic       redirect;
   word_t      redirectPc;
   logic       haltSeen;

   fetch #(.imemDepth(imemDepth)) fetchStage (
      .clk        (clk),
      .rst        (rst),
      .progWe     (progWe),
      .progAddr   (progAddr),
      .progInstr  (progInstr),
      .redirect   (redirect),
      .redirectPc (redirectPc),
      .haltSeen   (haltSeen),
      .fetched    (fetchedBus)
   );

   decode decodeStage (
      .clk        (clk),
      .rst        (rst),
      .fetched    (fetchedBus),
      .write      (writeBus),      // Writeback from execute into the register file
      .redirect   (redirect),
      .redirectPc (redirectPc),
      .haltSeen   (haltSeen),
      .decoded    (decodedBus)
   );

   execute executeStage (
      .clk     (clk),
      .rst     (rst),
      .decoded (decodedBus),
      .write   (writeBus),
      .retire  (retire),
      .halted  (halted)
   );

   // Decode keeps the HALT's PC in operand A once nothing follows it
   assign haltPc = decodedBus.opA;

endmodule

/* logic/wiscIsaPkg.sv */
// ******************************
// Instruction set definitions: data and register types,
// opcode enumeration, the four instruction formats and
// the instruction union over one 16-bit word
// ******************************
package wiscIsaPkg;

   typedef logic [15:0] word_t;     // Data word and byte address alike
   typedef logic [2:0]  regAddr_t;  // One of R0..R7

   // Only the opcodes this core executes are named
   typedef enum logic [4:0] {
      opHalt = 5'b00000,
      opNop  = 5'b00001,
      opJ    = 5'b00100,
      opJr   = 5'b00101,
      opJal  = 5'b00110,
      opJalr = 5'b00111,
      opAddi = 5'b01000,
      opSubi = 5'b01001,
      opBeqz = 5'b01100,
      opBnez = 5'b01101,
      opBltz = 5'b01110,
      opBgez = 5'b01111,
      opLbi  = 5'b11000,
      opAluR = 5'b11011   // ADD and SUB, told apart by the function field
   } opcode_t;

   // Function field values inside opAluR
   localparam logic [1:0] funcAdd = 2'b00;
   localparam logic [1:0] funcSub = 2'b01;

   // Immediate arithmetic, five bit immediate
   typedef struct packed {
      opcode_t    opcode;
      regAddr_t   rs;
      regAddr_t   rd;
      logic [4:0] imm;
   } iFormat_t;

   // Register to register arithmetic
   typedef struct packed {
      opcode_t    opcode;
      regAddr_t   rs;
      regAddr_t   rt;
      regAddr_t   rd;
      logic [1:0] func;
   } rFormat_t;

   // Branches, LBI, JR and JALR share the eight bit immediate
   typedef struct packed {
      opcode_t    opcode;
      regAddr_t   rs;
      logic [7:0] imm;
   } bFormat_t;

   typedef struct packed {
      opcode_t     opcode;
      logic [10:0] disp;   // PC relative, counted from PC+2
   } jFormat_t;

   // One fetched word, seen through whichever format the opcode selects
   typedef union packed {
      iFormat_t i;
      rFormat_t r;
      bFormat_t b;
      jFormat_t j;
   } instr_u;

   localparam regAddr_t linkReg = 3'd7;  // JAL and JALR write their return address here

endpackage

/* logic/wiscPipePkg.sv */
// ******************************
// Pipeline records: fetch to decode word, decode to
// execute operation, and the writeback request
// ******************************
package wiscPipePkg;

   import wiscIsaPkg::*;

   // What execute does with the operands
   typedef enum logic [2:0] {
      aluAdd,    // A plus B
      aluSub,    // B minus A
      aluAddI,   // A plus immediate
      aluSubI,   // Immediate minus A
      aluPass    // B unchanged, used by LBI and the links
   } aluOp_t;

   typedef struct packed {
      logic   valid;
      word_t  pc;      // Address the word came from
      instr_u instr;
   } fetchOut_t;

   typedef struct packed {
      logic     valid;
      logic     halt;
      aluOp_t   op;
      regAddr_t dest;
      logic     writes;  // Set when the instruction writes a register
      word_t    opA;     // Rs, or the HALT's own PC
      word_t    opB;     // Rt, LBI immediate or PC+2
      word_t    imm;     // Sign extended by format
   } decodeOut_t;

   typedef struct packed {
      logic     valid;
      regAddr_t addr;
      word_t    data;
   } wbReq_t;

endpackage

/* tb/wiscCoreCases.svh */
// ******************************
// Test programs with their expected writebacks
// and halt addresses
// ******************************
localparam int numProgs = 4;

word_t  progTable [numProgs][maxWords];
wbReq_t wbTable   [numProgs][maxWords];
int     wordCount [numProgs];
int     wbCount   [numProgs];
word_t  haltTable [numProgs];

task automatic addWord(int p, word_t w);
   progTable[p][wordCount[p]] = w;
   wordCount[p]++;
endtask

// A word that retires exactly one register write
task automatic addWordWb(int p, word_t w, regAddr_t addr, word_t data);
   addWord(p, w);
   wbTable[p][wbCount[p]] = '{valid: 1'b1, addr: addr, data: data};
   wbCount[p]++;
endtask

// HALT ends a program and haltPc must report its address
task automatic addHalt(int p, word_t pc);
   addWord(p, encB(opHalt, 0, 8'd0));
   haltTable[p] = pc;
endtask

task automatic buildCases();
   for (int p = 0; p < numProgs; p++) begin
      wordCount[p] = 0;
      wbCount[p]   = 0;
      for (int w = 0; w < maxWords; w++) progTable[p][w] = {opNop, 11'd0};
   end
   // ALU chain where each result feeds the next
   addWordWb(0, encB(opLbi, 1, 8'd5), 1, 16'h0005);
   addWordWb(0, encI(opAddi, 1, 2, 5'd3), 2, 16'h0008);
   addWordWb(0, encI(opSubi, 2, 3, 5'h1e), 3, 16'hfff6);   // -2 minus 8
   addWordWb(0, encR(2, 3, 4, funcAdd), 4, 16'hfffe);
   addWordWb(0, encR(1, 4, 5, funcSub), 5, 16'hfff9);      // Rt minus Rs
   addWordWb(0, encB(opLbi, 6, 8'h80), 6, 16'hff80);
   addHalt(0, 16'd12);
   // Branch set with BEQZ taken, BNEZ not, BLTZ taken, BGEZ not, BLTZ not, BGEZ taken
   addWordWb(1, encB(opLbi, 1, 8'd0), 1, 16'h0000);
   addWord(1, encB(opBeqz, 1, 8'd2));
   addWord(1, encB(opLbi, 2, 8'd1));            // Skipped
   addWord(1, encB(opBnez, 1, 8'd2));
   addWordWb(1, encB(opLbi, 3, 8'hff), 3, 16'hffff);
   addWord(1, encB(opBltz, 3, 8'd2));
   addWord(1, encB(opLbi, 4, 8'd9));            // Skipped
   addWord(1, encB(opBgez, 3, 8'd4));           // A wrong take lands on the LBI of R5
   addWord(1, encB(opBltz, 1, 8'd2));
   addWord(1, encB(opBgez, 1, 8'd2));
   addWord(1, encB(opLbi, 5, 8'd7));            // Skipped
   addHalt(1, 16'd22);
   // R6 must read zero again after reset before BEQZ falls through and BNEZ is taken
   addWordWb(2, encI(opAddi, 6, 1, 5'd3), 1, 16'h0003);
   addWord(2, encB(opBeqz, 1, 8'd2));           // A wrong take runs the LBI of R2
   addWord(2, encB(opBnez, 1, 8'd2));
   addWord(2, encB(opLbi, 2, 8'd1));            // Skipped
   addWordWb(2, encI(opAddi, 1, 2, 5'd1), 2, 16'h0004);
   addHalt(2, 16'd10);
   addWord(2, encB(opBeqz, 0, 8'hf4));          // Taken if it ever ran
   addWord(2, encB(opLbi, 7, 8'd1));
   // Jumps and links
   addWord(3, encJ(opJ, 11'd2));
   addWord(3, encB(opLbi, 1, 8'd1));
   addWordWb(3, encJ(opJal, 11'd4), 7, 16'h0006);
   addWord(3, encB(opLbi, 1, 8'd2));
   addWord(3, encB(opLbi, 1, 8'd3));
   addWordWb(3, encB(opLbi, 2, 8'd16), 2, 16'h0010);
   addWord(3, encB(opJr, 2, 8'd0));
   addWord(3, encB(opLbi, 1, 8'd4));
   addWordWb(3, encB(opJalr, 2, 8'd6), 7, 16'h0012);  // Jumps over two words to the HALT
   addWord(3, encB(opLbi, 1, 8'd5));
   addWord(3, encB(opLbi, 1, 8'd6));
   addHalt(3, 16'd22);
endtask

/* tb/wiscCoreTb.sv */
`timescale 1ns/1ps
// ******************************
// Core testbench: clock, reset, program loading,
// retire monitor, compare tasks and result line
// ******************************
module wiscCoreTb import wiscIsaPkg::*, wiscPipePkg::*; ();

   localparam int maxWords = 12;
   localparam int depth    = 64;

   logic   clk;
   logic   rst;
   logic   progWe;
   word_t  progAddr;
   instr_u progInstr;
   wbReq_t retire;
   logic   halted;
   word_t  haltPc;

   int mismatchCount = 0;
   int otherCount    = 0;

   // One instruction encoder per format of the ISA
   function automatic word_t encI(opcode_t op, regAddr_t rs, regAddr_t rd, logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic word_t encR(regAddr_t rs, regAddr_t rt, regAddr_t rd, logic [1:0] func);
      return {opAluR, rs, rt, rd, func};
   endfunction

   function automatic word_t encB(opcode_t op, regAddr_t rs, logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   function automatic word_t encJ(opcode_t op, logic [10:0] disp);
      return {op, disp};
   endfunction

   `include "wiscCoreCases.svh"

   wiscCore #(.imemDepth(depth)) dut_i (
      .clk       (clk),
      .rst       (rst),
      .progWe    (progWe),
      .progAddr  (progAddr),
      .progInstr (progInstr),
      .retire    (retire),
      .halted    (halted),
      .haltPc    (haltPc)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;   // 20 ns period
   end

   task automatic checkWriteback(wbReq_t got, wbReq_t exp, int prog, int idx);
      if (got !== exp) begin
         mismatchCount++;
         $display("mismatch at %0t: program %0d retire %0d wrote R%0d=%h, expected R%0d=%h",
                  $time, prog, idx, got.addr, got.data, exp.addr, exp.data);
      end
   endtask

   task automatic checkHaltPc(word_t got, word_t exp, int prog);
      if (got !== exp) begin
         mismatchCount++;
         $display("mismatch at %0t: program %0d halted at PC %h, expected %h",
                  $time, prog, got, exp);
      end
   endtask

   // Whole memory is rewritten under reset and unused words get NOPs with random filler
   task automatic loadProgram(int p);
      word_t fill;
      @(posedge clk);
      #2;
      rst = 1'b1;
      for (int a = 0; a < depth; a++) begin
         fill      = {opNop, 11'($urandom) ^ 11'(a)};
         progWe    = 1'b1;
         progAddr  = word_t'(a * 2);
         progInstr = instr_u'((a < maxWords) ? progTable[p][a] : fill);
         @(posedge clk);
         #2;
      end
      progWe = 1'b0;
      repeat (4) begin
         @(posedge clk);
      end
      #2 rst = 1'b0;
   endtask

   task automatic runProgram(int p);
      int idx;
      int cycles;
      idx    = 0;
      cycles = 0;
      loadProgram(p);
      // Outputs are registered so the falling edge sees them settled
      while (!halted && cycles < 200) begin
         @(negedge clk);
         cycles++;
         if (retire.valid) begin
            if (idx < wbCount[p]) begin
               checkWriteback(retire, wbTable[p][idx], p, idx);
            end else begin
               otherCount++;
               $display("program %0d retired an extra write to R%0d at %0t",
                        p, retire.addr, $time);
            end
            idx++;
         end
      end
      if (!halted) begin
         otherCount++;
         $display("program %0d never halted within 200 cycles", p);
      end
      // Nothing may retire once the core has halted
      repeat (5) begin
         @(negedge clk);
         if (retire.valid) begin
            otherCount++;
            $display("program %0d retired R%0d after halting", p, retire.addr);
         end
      end
      if (idx < wbCount[p]) begin
         otherCount++;
         $display("program %0d retired %0d writes but %0d were expected", p, idx, wbCount[p]);
      end
      checkHaltPc(haltPc, haltTable[p], p);
   endtask

   initial begin
      rst       = 1'b1;
      progWe    = 1'b0;
      progAddr  = '0;
      progInstr = '0;
      void'($urandom(96441));
      buildCases();
      // Second pass repeats every program after a fresh reset
      for (int r = 0; r < 2 * numProgs; r++) begin
         runProgram(r % numProgs);
      end
      $display("errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
      if (mismatchCount == 0 && otherCount == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

/* wisc16.f */
+incdir+tb
logic/wiscIsaPkg.sv
logic/wiscPipePkg.sv
logic/fetch.sv
logic/regFile.sv
logic/decode.sv
logic/execute.sv
logic/wiscCore.sv
tb/wiscCoreTb.sv
